//--- src/osd_consts.svh
/*
  OSD overlay constants
  raster and color widths, bitmap depth, window sizes and the
  display-size thresholds that pick them
*/
`ifndef OSD_CONSTS_SVH
`define OSD_CONSTS_SVH

// raster counters and one color channel
`define OSD_CNT_W          11
`define OSD_COLOR_W        6

// bitmap memory, 8 line blocks of 256 bytes
`define OSD_BUF_DEPTH      2048

// display size thresholds
`define OSD_WIDE_LIMIT     1000
`define OSD_TALL_LIMIT     400

// window size in pixels and lines
`define OSD_WIN_W_NARROW   256
`define OSD_WIN_W_WIDE     512
`define OSD_WIN_H_SHORT    64
`define OSD_WIN_H_TALL     128

// frame border around the window
`define OSD_BORDER_X       4
`define OSD_BORDER_Y_SHORT 2
`define OSD_BORDER_Y_TALL  4

`endif

//--- src/video_pkg.sv
/*
  video geometry types
  raster counts, color channels and the timing meter states
*/
`include "osd_consts.svh"

package video_pkg;

  // --------------------------------------------------------------------------
  // raster geometry
  // --------------------------------------------------------------------------

  // pixel or line counter, also used for a measured phase length
  typedef logic [`OSD_CNT_W-1:0] count_t;

  // one channel of the 18-bit rgb stream
  typedef logic [`OSD_COLOR_W-1:0] color_t;

  // --------------------------------------------------------------------------
  // timing meter
  // --------------------------------------------------------------------------

  // idle until the first vs edge, then measure two full frames
  typedef enum logic [1:0] {
    MEAS_IDLE   = 2'd0,
    MEAS_LINE   = 2'd1,
    // lengths stable, geometry may be used
    MEAS_LOCKED = 2'd2
  } meter_state_e;

endpackage

//--- src/osd_cmd_pkg.sv
/*
  OSD command side types
  opcodes, receiver states, bitmap address and byte
*/
`include "osd_consts.svh"

package osd_cmd_pkg;

  // top 5 bits of the command byte
  typedef enum logic [4:0] {
    OP_WRITE  = 5'b00100,
    OP_ENABLE = 5'b01000,
    // any code this core does not handle
    OP_OTHER  = 5'b11111
  } osd_opcode_e;

  // first byte is the command, the rest is payload or skipped
  typedef enum logic [1:0] {
    RX_COMMAND = 2'd0,
    RX_PAYLOAD = 2'd1,
    RX_IGNORE  = 2'd2
  } rx_state_e;

  typedef logic [$clog2(`OSD_BUF_DEPTH)-1:0] buf_addr_t;
  typedef logic [7:0]                        osd_byte_t;

  // map a command byte onto the supported opcodes
  function automatic osd_opcode_e decode_opcode(input osd_byte_t cmd);
    case (cmd[7:3])
      OP_WRITE:  return OP_WRITE;
      OP_ENABLE: return OP_ENABLE;
      default:   return OP_OTHER;
    endcase
  endfunction

endpackage

//--- src/video_timing_meter.sv
/*
  video timing meter
  measures hs and vs phase lengths, derives display size and
  keeps the pixel and line counters of the incoming raster
*/
`timescale 1ns/1ns

module video_timing_meter
  import video_pkg::*;
(
  input  logic   clk,
  input  logic   ss,
  input  logic   hs,
  input  logic   vs,
  output count_t hcnt,
  output count_t vcnt,
  output count_t disp_w,
  output count_t disp_h,
  output logic   geom_valid
);

  // sync inputs delayed once, used as previous level
  logic         hs_q;
  logic         vs_q;
  logic         hs_edge;
  logic         vs_edge;
  logic         line_end;
  logic         hs_pol;
  logic         vs_pol;
  count_t       hs_high;
  count_t       hs_low;
  count_t       vs_high;
  count_t       vs_low;
  meter_state_e state;
  logic [1:0]   vs_edges;

  assign hs_edge = hs != hs_q;
  assign vs_edge = vs != vs_q;

  // sync level is the shorter phase
  assign hs_pol = hs_high < hs_low;
  assign vs_pol = vs_high < vs_low;

  // a line ends where hs enters its sync phase
  assign line_end = hs_edge && (hs == hs_pol);

  // visible size is the longer phase
  assign disp_w = hs_pol ? hs_low : hs_high;
  assign disp_h = vs_pol ? vs_low : vs_high;

  assign geom_valid = state == MEAS_LOCKED;

  // --------------------------------------------------------------------------
  // counters and phase lengths
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      hs_q    <= 1'b0;
      vs_q    <= 1'b0;
      hcnt    <= '0;
      vcnt    <= '0;
      hs_high <= '0;
      hs_low  <= '0;
      vs_high <= '0;
      vs_low  <= '0;
    end else begin
      hs_q <= hs;
      vs_q <= vs;
      // rising hs closes a low phase
      if (hs_edge) begin
        if (hs)
          hs_low <= hcnt + count_t'(1);
        else
          hs_high <= hcnt + count_t'(1);
        hcnt <= '0;
      end else begin
        hcnt <= hcnt + count_t'(1);
      end
      // a line ending on the vs edge still counts for the old phase
      if (vs_edge) begin
        if (vs)
          vs_low <= vcnt + count_t'(line_end);
        else
          vs_high <= vcnt + count_t'(line_end);
        vcnt <= '0;
      end else if (line_end) begin
        vcnt <= vcnt + count_t'(1);
      end
    end
  end

  // --------------------------------------------------------------------------
  // lock after four vs edges, two full frames
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      state    <= MEAS_IDLE;
      vs_edges <= '0;
    end else begin
      case (state)
        MEAS_IDLE: begin
          if (vs_edge) begin
            state    <= MEAS_LINE;
            vs_edges <= '0;
          end
        end
        MEAS_LINE: begin
          if (vs_edge) begin
            vs_edges <= vs_edges + 2'd1;
            if (vs_edges == 2'd3)
              state <= MEAS_LOCKED;
          end
        end
        MEAS_LOCKED: state <= MEAS_LOCKED;
        default:     state <= MEAS_IDLE;
      endcase
    end
  end

  // a locked raster always has a measured line
  a_width_known: assert property (@(posedge clk) disable iff (ss)
    geom_valid |-> disp_w != '0);

endmodule

//--- src/osd_spi_receiver.sv
/*
  OSD serial command receiver
  oversamples sck, shifts in bytes msb first, decodes enable and
  line write commands and streams bitmap bytes to the buffer
*/
`timescale 1ns/1ns

module osd_spi_receiver
  import osd_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      ss,
  input  logic      sck,
  input  logic      sel_n,
  input  logic      sdi,
  output logic      wr_en,
  output buf_addr_t wr_addr,
  output osd_byte_t wr_data,
  output logic      osd_on
);

  // two sync stages, third sck stage for edge detect
  logic [2:0]  sck_sync;
  logic [1:0]  sel_sync;
  logic [1:0]  sdi_sync;
  logic        sck_rise;
  logic        byte_done;
  logic [2:0]  bit_cnt;
  logic [6:0]  sbuf;
  osd_byte_t   rx_byte;
  osd_opcode_e opcode;
  rx_state_e   state;
  buf_addr_t   addr_q;

  assign sck_rise  = sck_sync[1] && !sck_sync[2];
  assign byte_done = sck_rise && !sel_sync[1] && (bit_cnt == 3'd7);
  // complete byte including the bit sampled now
  assign rx_byte   = {sbuf, sdi_sync[1]};
  assign opcode    = decode_opcode(rx_byte);

  // --------------------------------------------------------------------------
  // synchronizers and command FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      sck_sync <= '0;
      sel_sync <= 2'b11;
      sdi_sync <= '0;
      bit_cnt  <= '0;
      state    <= RX_COMMAND;
      wr_en    <= 1'b0;
      osd_on   <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[1:0], sck};
      sel_sync <= {sel_sync[0], sel_n};
      sdi_sync <= {sdi_sync[0], sdi};
      wr_en    <= 1'b0;
      if (sel_sync[1]) begin
        // deselected, next transfer starts with a command
        bit_cnt <= '0;
        state   <= RX_COMMAND;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (byte_done) begin
          case (state)
            RX_COMMAND: begin
              case (opcode)
                OP_WRITE: state <= RX_PAYLOAD;
                OP_ENABLE: begin
                  osd_on <= rx_byte[0];
                  state  <= RX_IGNORE;
                end
                default: state <= RX_IGNORE;
              endcase
            end
            RX_PAYLOAD: wr_en <= 1'b1;
            RX_IGNORE:  state <= RX_IGNORE;
            default:    state <= RX_COMMAND;
          endcase
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // shift register and write address
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (sck_rise && !sel_sync[1])
      sbuf <= rx_byte[6:0];
    if (byte_done) begin
      // low 3 command bits select a 256 byte line block
      if (state == RX_COMMAND)
        addr_q <= {rx_byte[2:0], 8'h00};
      if (state == RX_PAYLOAD) begin
        wr_addr <= addr_q;
        wr_data <= rx_byte;
        addr_q  <= addr_q + buf_addr_t'(1);
      end
    end
  end

  // writes only come out of a write burst
  a_wr_in_payload: assert property (@(posedge clk) disable iff (ss)
    wr_en |-> state == RX_PAYLOAD);

endmodule

//--- src/osd_char_buffer.sv
/*
  OSD bitmap memory
  2048 bytes, one write port from the serial receiver and one
  registered read port for the window mixer
*/
`timescale 1ns/1ns
`include "osd_consts.svh"

module osd_char_buffer
  import osd_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      wr_en,
  input  buf_addr_t wr_addr,
  input  buf_addr_t rd_addr,
  input  osd_byte_t wr_data,
  output osd_byte_t rd_data
);

  // one byte holds 8 vertical pixels of a column
  osd_byte_t mem [`OSD_BUF_DEPTH];

  // write port
  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // read port
  // data follows the address by one clock
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // address comes from the receiver burst counter
  a_wr_addr_known: assert property (@(posedge clk)
    wr_en |-> !$isunknown(wr_addr));

endmodule

//--- src/osd_window_mixer.sv
/*
  OSD window mixer
  places a centred window with border over the video, fetches the
  bitmap byte per pixel and blends it into the delayed rgb stream
*/
`timescale 1ns/1ns
`include "osd_consts.svh"

module osd_window_mixer
  import video_pkg::*, osd_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      ss,
  input  count_t    hcnt,
  input  count_t    vcnt,
  input  count_t    disp_w,
  input  count_t    disp_h,
  input  logic      geom_valid,
  input  logic      osd_on,
  input  color_t    r_in,
  input  color_t    g_in,
  input  color_t    b_in,
  output buf_addr_t rd_addr,
  input  osd_byte_t rd_data,
  output color_t    r_out,
  output color_t    g_out,
  output color_t    b_out
);

  logic       wide;
  logic       tall;
  count_t     win_w;
  count_t     win_h;
  count_t     border_y;
  count_t     pos_x;
  count_t     pos_y;
  count_t     col;
  count_t     row;
  logic       in_frame;
  logic       in_content;
  // stage 1, aligned with rd_data
  logic       act_q;
  logic       frame_q;
  logic       content_q;
  logic [2:0] bit_q;
  color_t     r_q;
  color_t     g_q;
  color_t     b_q;
  logic       pixel;

  // --------------------------------------------------------------------------
  // window geometry
  // --------------------------------------------------------------------------

  assign wide = (disp_w > count_t'(`OSD_WIDE_LIMIT)) && (disp_h < count_t'(`OSD_WIDE_LIMIT));
  assign tall = disp_h > count_t'(`OSD_TALL_LIMIT);

  assign win_w    = wide ? count_t'(`OSD_WIN_W_WIDE) : count_t'(`OSD_WIN_W_NARROW);
  assign win_h    = tall ? count_t'(`OSD_WIN_H_TALL) : count_t'(`OSD_WIN_H_SHORT);
  assign border_y = tall ? count_t'(`OSD_BORDER_Y_TALL) : count_t'(`OSD_BORDER_Y_SHORT);

  // centre the window
  assign pos_x = (disp_w - win_w) >> 1;
  assign pos_y = (disp_h - win_h) >> 1;

  assign in_frame = (hcnt >= pos_x - count_t'(`OSD_BORDER_X)) &&
                    (hcnt < pos_x + win_w + count_t'(`OSD_BORDER_X)) &&
                    (vcnt >= pos_y - border_y) &&
                    (vcnt < pos_y + win_h + border_y);

  assign in_content = (hcnt >= pos_x) && (hcnt <= pos_x + win_w - count_t'(1)) &&
                      (vcnt >= pos_y) && (vcnt <= pos_y + win_h - count_t'(1));

  // bitmap coordinates, doubled pixels on large displays
  assign col = wide ? (hcnt - pos_x) >> 1 : hcnt - pos_x;
  assign row = tall ? (vcnt - pos_y) >> 1 : vcnt - pos_y;

  // line block from row, byte from column
  assign rd_addr = {row[5:3], col[7:0]};

  // --------------------------------------------------------------------------
  // pipeline and overlay
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      act_q     <= 1'b0;
      frame_q   <= 1'b0;
      content_q <= 1'b0;
    end else begin
      act_q     <= osd_on && geom_valid;
      frame_q   <= in_frame;
      content_q <= in_content;
    end
  end

  always_ff @(posedge clk) begin
    bit_q <= row[2:0];
    r_q   <= r_in;
    g_q   <= g_in;
    b_q   <= b_in;
  end

  // border band shows a dark pixel
  assign pixel = content_q && rd_data[bit_q];

  // window keeps the top 3 video bits as a dimmed background
  always_ff @(posedge clk) begin
    if (act_q && frame_q) begin
      r_out <= {{3{pixel}}, r_q[`OSD_COLOR_W-1 -: 3]};
      g_out <= {{2{pixel}}, 1'b1, g_q[`OSD_COLOR_W-1 -: 3]};
      b_out <= {{3{pixel}}, b_q[`OSD_COLOR_W-1 -: 3]};
    end else begin
      r_out <= r_q;
      g_out <= g_q;
      b_out <= b_q;
    end
  end

endmodule

//--- src/osd_overlay.sv
/*
  OSD overlay top level
  timing meter, serial receiver, bitmap buffer and window mixer
*/
`timescale 1ns/1ns

module osd_overlay
  import video_pkg::*, osd_cmd_pkg::*;
(
  input  logic   clk,
  input  logic   ss,
  input  logic   sck,
  input  logic   sel_n,
  input  logic   sdi,
  input  logic   hs,
  input  logic   vs,
  input  color_t r_in,
  input  color_t g_in,
  input  color_t b_in,
  output color_t r_out,
  output color_t g_out,
  output color_t b_out
);

  // raster position and measured size
  count_t    hcnt;
  count_t    vcnt;
  count_t    disp_w;
  count_t    disp_h;
  logic      geom_valid;
  // command side
  logic      osd_on;
  logic      wr_en;
  buf_addr_t wr_addr;
  osd_byte_t wr_data;
  // bitmap read port
  buf_addr_t rd_addr;
  osd_byte_t rd_data;

  video_timing_meter u_meter (
    .clk        (clk),
    .ss         (ss),
    .hs         (hs),
    .vs         (vs),
    .hcnt       (hcnt),
    .vcnt       (vcnt),
    .disp_w     (disp_w),
    .disp_h     (disp_h),
    .geom_valid (geom_valid)
  );

  osd_spi_receiver u_receiver (
    .clk     (clk),
    .ss      (ss),
    .sck     (sck),
    .sel_n   (sel_n),
    .sdi     (sdi),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .osd_on  (osd_on)
  );

  osd_char_buffer u_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  osd_window_mixer u_mixer (
    .clk        (clk),
    .ss         (ss),
    .hcnt       (hcnt),
    .vcnt       (vcnt),
    .disp_w     (disp_w),
    .disp_h     (disp_h),
    .geom_valid (geom_valid),
    .osd_on     (osd_on),
    .r_in       (r_in),
    .g_in       (g_in),
    .b_in       (b_in),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .r_out      (r_out),
    .g_out      (g_out),
    .b_out      (b_out)
  );

endmodule

//--- test/osd_overlay_tb.sv
/*
  OSD overlay testbench
  drives a fixed raster and SPI commands, checks pass-through and
  window pixels against a table of sample points
*/
`timescale 1ns/1ns
`include "osd_consts.svh"

module osd_overlay_tb
  import video_pkg::*, osd_cmd_pkg::*;
();

  // --------------------------------------------------------------------------
  // raster and run limits
  // --------------------------------------------------------------------------

  localparam int H_TOTAL     = 800;
  localparam int H_HIGH      = 704;
  localparam int V_TOTAL     = 525;
  localparam int V_HIGH      = 523;
  localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;
  // about 600 bytes at 64 clocks each
  localparam int SPI_CYC     = 600 * 64;
  localparam int TIMEOUT_CYC = 6 * FRAME_CYC + SPI_CYC + 2000;
  localparam logic [31:0] LCG_SEED = 32'h392a_0f92;

  logic   clk;
  logic   ss;
  logic   sck;
  logic   sel_n;
  logic   sdi;
  logic   hs = 1'b0;
  logic   vs = 1'b0;
  color_t r_in = '0;
  color_t g_in = '0;
  color_t b_in = '0;
  color_t r_out;
  color_t g_out;
  color_t b_out;

  // video generator state
  logic [31:0] vid_seed = LCG_SEED;
  int          hp = 0;
  int          ln = 0;
  int          frame_cnt = 0;
  // pixel currently on the inputs
  logic        drv_valid = 1'b0;
  int          drv_hp;
  int          drv_ln;
  color_t      drv_r;
  color_t      drv_g;
  color_t      drv_b;
  // two stage history since output lags input by two clocks
  logic        p1_valid = 1'b0;
  logic        p2_valid = 1'b0;
  int          p1_hp;
  int          p2_hp;
  int          p1_ln;
  int          p2_ln;
  color_t      p1_r;
  color_t      p1_g;
  color_t      p1_b;
  color_t      p2_r;
  color_t      p2_g;
  color_t      p2_b;

  // sample point request from the table loop
  int          req_id = 0;
  int          ack_id = 0;
  int          tgt_h;
  int          tgt_v;
  logic        tgt_en;
  string       tgt_name;
  logic        passthru_on = 1'b0;
  int          color_errors = 0;
  int          count_errors = 0;
  int          cycles = 0;

  osd_byte_t   bitmap_model [`OSD_BUF_DEPTH];
  osd_byte_t   spi_q [$];

  // table of sample points
  string       tbl_name [$];
  int          tbl_h [$];
  int          tbl_v [$];
  logic        tbl_en [$];

  osd_overlay UUT (
    .clk   (clk),
    .ss    (ss),
    .sck   (sck),
    .sel_n (sel_n),
    .sdi   (sdi),
    .hs    (hs),
    .vs    (vs),
    .r_in  (r_in),
    .g_in  (g_in),
    .b_in  (b_in),
    .r_out (r_out),
    .g_out (g_out),
    .b_out (b_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected output from the window rules and the bitmap copy
  function automatic void expected_rgb(input int h, input int v, input logic en,
                                       input color_t ri, input color_t gi,
                                       input color_t bi, output color_t ro,
                                       output color_t go, output color_t bo);
    int   dw;
    int   dh;
    int   win_w;
    int   win_h;
    int   by;
    int   px;
    int   py;
    int   col;
    int   row;
    int   addr;
    logic wide;
    logic tall;
    logic frame;
    logic content;
    logic pix;
    dw    = H_HIGH;
    dh    = V_HIGH;
    wide  = (dw > `OSD_WIDE_LIMIT) && (dh < `OSD_WIDE_LIMIT);
    tall  = dh > `OSD_TALL_LIMIT;
    win_w = wide ? `OSD_WIN_W_WIDE : `OSD_WIN_W_NARROW;
    win_h = tall ? `OSD_WIN_H_TALL : `OSD_WIN_H_SHORT;
    by    = tall ? `OSD_BORDER_Y_TALL : `OSD_BORDER_Y_SHORT;
    px    = (dw - win_w) / 2;
    py    = (dh - win_h) / 2;
    frame = (h >= px - `OSD_BORDER_X) && (h < px + win_w + `OSD_BORDER_X) &&
            (v >= py - by) && (v < py + win_h + by);
    content = (h >= px) && (h < px + win_w) && (v >= py) && (v < py + win_h);
    col = wide ? (h - px) / 2 : h - px;
    row = tall ? (v - py) / 2 : v - py;
    // line block from row bits 5..3 and byte from the column
    addr = ((row / 8) % 8) * 256 + (col % 256);
    pix  = content ? bitmap_model[addr][row % 8] : 1'b0;
    if (en && frame) begin
      ro = {{3{pix}}, ri[`OSD_COLOR_W-1 -: 3]};
      go = {{2{pix}}, 1'b1, gi[`OSD_COLOR_W-1 -: 3]};
      bo = {{3{pix}}, bi[`OSD_COLOR_W-1 -: 3]};
    end else begin
      ro = ri;
      go = gi;
      bo = bi;
    end
  endfunction

  task automatic check_color(input string name, input color_t exp, input color_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %h actual %h", name, exp, act);
      color_errors = color_errors + 1;
    end
  endtask

  task automatic check_count(input string name, input count_t exp, input count_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %0d actual %0d", name, exp, act);
      count_errors = count_errors + 1;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one byte msb first with each sck level held 4 clocks
  task automatic spi_byte(input osd_byte_t b);
    for (int i = 7; i >= 0; i--) begin
      sdi <= b[i];
      sck <= 1'b0;
      wait_cycles(4);
      sck <= 1'b1;
      wait_cycles(4);
    end
  endtask

  // whole transfer of spi_q framed by sel_n
  task automatic spi_send();
    sel_n <= 1'b0;
    wait_cycles(4);
    foreach (spi_q[i])
      spi_byte(spi_q[i]);
    sck <= 1'b0;
    wait_cycles(4);
    sel_n <= 1'b1;
    wait_cycles(8);
    spi_q.delete();
  endtask

  task automatic add_entry(input string name, input int h, input int v, input logic en);
    tbl_name.push_back(name);
    tbl_h.push_back(h);
    tbl_v.push_back(v);
    tbl_en.push_back(en);
  endtask

  // --------------------------------------------------------------------------
  // video generator for an 800 x 525 raster with random colors
  // --------------------------------------------------------------------------

  always @(posedge clk) begin : video_gen
    logic [31:0] nxt;
    if (!ss) begin
      nxt = lcg_next(vid_seed);
      vid_seed  <= nxt;
      hs        <= hp < H_HIGH;
      vs        <= ln < V_HIGH;
      r_in      <= nxt[31:26];
      g_in      <= nxt[25:20];
      b_in      <= nxt[19:14];
      drv_valid <= 1'b1;
      drv_hp    <= hp;
      drv_ln    <= ln;
      drv_r     <= nxt[31:26];
      drv_g     <= nxt[25:20];
      drv_b     <= nxt[19:14];
      if (hp == H_TOTAL - 1) begin
        hp <= 0;
        if (ln == V_TOTAL - 1) begin
          ln        <= 0;
          frame_cnt <= frame_cnt + 1;
        end else begin
          ln <= ln + 1;
        end
      end else begin
        hp <= hp + 1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // output checker on the falling edge
  // --------------------------------------------------------------------------

  always @(negedge clk) begin : out_check
    color_t er;
    color_t eg;
    color_t eb;
    if (!ss) begin
      if (p2_valid && passthru_on) begin
        check_color("passthru_r", p2_r, r_out);
        check_color("passthru_g", p2_g, g_out);
        check_color("passthru_b", p2_b, b_out);
      end
      // hcnt lags the generator by one pixel in the visible phase
      if (p2_valid && req_id != ack_id && p2_hp == tgt_h + 1 && p2_ln == tgt_v) begin
        expected_rgb(tgt_h, tgt_v, tgt_en, p2_r, p2_g, p2_b, er, eg, eb);
        check_color({tgt_name, "_r"}, er, r_out);
        check_color({tgt_name, "_g"}, eg, g_out);
        check_color({tgt_name, "_b"}, eb, b_out);
        ack_id <= req_id;
      end
      p2_valid <= p1_valid;
      p2_hp    <= p1_hp;
      p2_ln    <= p1_ln;
      p2_r     <= p1_r;
      p2_g     <= p1_g;
      p2_b     <= p1_b;
      p1_valid <= drv_valid;
      p1_hp    <= drv_hp;
      p1_ln    <= drv_ln;
      p1_r     <= drv_r;
      p1_g     <= drv_g;
      p1_b     <= drv_b;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles, sample point %s never reached", cycles, tgt_name);
      $display("errors: color %0d count %0d", color_errors, count_errors);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin : main_seq
    logic [31:0] seed;
    logic        cur_en;
    int          f_now;
    ss    = 1'b1;
    sck   = 1'b0;
    sel_n = 1'b1;
    sdi   = 1'b0;
    // bitmap copy with random blocks 0 and 1 and zero elsewhere
    seed = LCG_SEED;
    for (int a = 0; a < `OSD_BUF_DEPTH; a++) begin
      seed = lcg_next(seed);
      bitmap_model[a] = (a < 512) ? seed[23:16] : 8'h00;
    end
    // window at x 224..479 and y 197..324 with a border of 4 around it
    add_entry("outside_top", 300, 192, 1'b1);
    add_entry("border_top", 300, 194, 1'b1);
    add_entry("content_a", 224, 197, 1'b1);
    add_entry("content_b", 260, 200, 1'b1);
    add_entry("content_c", 479, 210, 1'b1);
    add_entry("outside_left", 219, 215, 1'b1);
    add_entry("border_left", 221, 215, 1'b1);
    add_entry("outside_right", 484, 215, 1'b1);
    add_entry("border_right", 483, 216, 1'b1);
    add_entry("content_e", 400, 225, 1'b1);
    add_entry("content_d", 350, 228, 1'b1);
    add_entry("border_bottom", 300, 328, 1'b1);
    add_entry("outside_bottom", 300, 329, 1'b1);
    add_entry("off_border", 300, 194, 1'b0);
    add_entry("off_content", 260, 200, 1'b0);
    add_entry("off_outside", 100, 300, 1'b0);
    // block 1 column 1 is where a stray OP_OTHER payload would land
    add_entry("again_a", 225, 214, 1'b1);
    add_entry("again_b", 333, 226, 1'b1);
    add_entry("again_border", 222, 300, 1'b1);

    repeat (8) @(posedge clk);
    ss <= 1'b0;
    wait_cycles(4);

    // unlocked and disabled means a plain two clock delay
    passthru_on = 1'b1;
    wait_cycles(1000);
    passthru_on = 1'b0;

    // enable first and then fill line blocks 0 and 1
    spi_q.push_back(8'h41);
    spi_send();
    for (int blk = 0; blk < 2; blk++) begin
      spi_q.push_back(8'h20 | osd_byte_t'(blk));
      for (int a = 0; a < 256; a++)
        spi_q.push_back(bitmap_model[blk * 256 + a]);
      spi_send();
    end
    cur_en = 1'b1;

    // geometry locks early in frame 2
    wait (frame_cnt >= 2);
    @(posedge clk);

    // display size is the longer phase of each sync signal
    check_count("disp_w", count_t'(H_HIGH), UUT.disp_w);
    check_count("disp_h", count_t'(V_HIGH), UUT.disp_h);

    foreach (tbl_name[e]) begin
      if (tbl_en[e] != cur_en) begin
        if (tbl_en[e]) begin
          spi_q.push_back(8'h41);
          spi_send();
        end else begin
          spi_q.push_back(8'h40);
          spi_send();
          // unsupported opcodes that must neither write nor enable
          // payload inverts bytes 256 and 257 so a stray write shows
          spi_q.push_back(8'h29);
          spi_q.push_back(~bitmap_model[256]);
          spi_q.push_back(~bitmap_model[257]);
          spi_send();
          spi_q.push_back(8'hf9);
          spi_send();
        end
        cur_en = tbl_en[e];
        f_now  = frame_cnt;
        wait (frame_cnt > f_now);
        @(posedge clk);
      end
      tgt_name = tbl_name[e];
      tgt_h    = tbl_h[e];
      tgt_v    = tbl_v[e];
      tgt_en   = tbl_en[e];
      req_id   = req_id + 1;
      wait (ack_id == req_id);
      @(posedge clk);
    end

    $display("errors: color %0d count %0d", color_errors, count_errors);
    if (color_errors + count_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- osd_overlay.f
+incdir+src
src/video_pkg.sv
src/osd_cmd_pkg.sv
src/video_timing_meter.sv
src/osd_spi_receiver.sv
src/osd_char_buffer.sv
src/osd_window_mixer.sv
src/osd_overlay.sv
test/osd_overlay_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the OSD overlay testbench with Verilator
# the run fails when the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --top-module osd_overlay_tb \
  -f osd_overlay.f -o osd_overlay_sim \
  && ./obj_dir/osd_overlay_sim > "$LOG" 2>&1 \
  || { echo "build or simulation error"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "Test failed" "$LOG" && exit 1 || exit 0
